//--- flist.f
src/resp_bank_pkg.sv
src/bank_ram.sv
src/free_slot_alloc.sv
src/id_queue_ctrl.sv
src/resp_out_stage.sv
src/resp_bank_top.sv
sim/tb_clk_gen.sv
sim/resp_bank_tb.sv

//--- sim/resp_bank_tb.sv
// Testbench of the response bank
// Random reservations, inputs, release enables and back-pressure run against
// a reference model, and concurrent assertions compare the DUT with it
`default_nettype none

module resp_bank_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import resp_bank_pkg::*;

  localparam int          ClkPeriod  = 20;
  localparam int          DriveDelay = 2;
  localparam int          NumTrans   = 600;
  localparam int unsigned Seed       = 32'h17cf0de5;

  // Handshakes of one cycle, taken mid-cycle when all ports are stable
  typedef struct packed {
    logic                    rsv_hs;
    resp_id_t                rsv_id;
    bank_addr_t              rsv_addr;
    logic                    in_hs;
    resp_id_t                in_id;
    logic [PayloadWidth-1:0] in_pay;
    logic                    out_hs;
    resp_id_t                out_id;
    logic                    load;
    logic [Capacity-1:0]     en;
  } cycle_snap_t;

  logic                clk;
  logic                rst_n;
  logic                i_rsv_valid;
  resp_id_t            i_rsv_id;
  logic                o_rsv_ready;
  bank_addr_t          o_rsv_addr;
  logic                i_in_valid;
  resp_t               i_in_resp;
  logic                o_in_ready;
  logic                o_out_valid;
  resp_t               o_out_resp;
  logic                i_out_ready;
  logic [Capacity-1:0] i_release_en;
  logic [Capacity-1:0] o_released_onehot;
  int                  err_cnt = 0;

  // Reference model with per-identifier slot lists in reservation order
  // The first fill_m entries of a list already hold a response
  bank_addr_t              lst_m  [NumIds][Capacity];
  int                      len_m  [NumIds];
  int                      fill_m [NumIds];
  logic [PayloadWidth-1:0] pay_m  [Capacity];
  logic [Capacity-1:0]     slot_v_m;
  logic [Capacity-1:0]     en_at_load;
  cycle_snap_t             snap;

  // Expected values derived from the model
  logic                    exp_full;
  bank_addr_t              exp_free_addr;
  logic                    exp_in_ok;
  bank_addr_t              exp_front_addr;
  logic                    exp_front_filled;
  logic [PayloadWidth-1:0] exp_front_pay;
  logic [Capacity-1:0]     exp_rel_onehot;

  tb_clk_gen #(
    .PeriodNs    (ClkPeriod),
    .ResetCycles (8)
  ) u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  resp_bank_top #(
    .NumIds       (NumIds),
    .Capacity     (Capacity),
    .PayloadWidth (PayloadWidth)
  ) u_resp_bank_top (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .i_rsv_valid       (i_rsv_valid),
    .i_rsv_id          (i_rsv_id),
    .o_rsv_ready       (o_rsv_ready),
    .o_rsv_addr        (o_rsv_addr),
    .i_in_valid        (i_in_valid),
    .i_in_resp         (i_in_resp),
    .o_in_ready        (o_in_ready),
    .o_out_valid       (o_out_valid),
    .o_out_resp        (o_out_resp),
    .i_out_ready       (i_out_ready),
    .i_release_en      (i_release_en),
    .o_released_onehot (o_released_onehot)
  );

  ////////////////////
  // Reference model
  ////////////////////

  always @(negedge clk) begin
    snap.rsv_hs   = i_rsv_valid && o_rsv_ready;
    snap.rsv_id   = i_rsv_id;
    snap.rsv_addr = exp_free_addr;
    snap.in_hs    = i_in_valid && o_in_ready;
    snap.in_id    = i_in_resp.id;
    snap.in_pay   = i_in_resp.payload;
    snap.out_hs   = o_out_valid && i_out_ready;
    snap.out_id   = o_out_resp.id;
    snap.load     = !o_out_valid || i_out_ready;
    snap.en       = i_release_en;
  end

  // Apply the cycle that just ended in the order output, input, reservation
  always @(posedge clk) begin
    int         id;
    bank_addr_t a;
    if (!rst_n) begin
      slot_v_m   = '0;
      en_at_load = '0;
      for (int i = 0; i < NumIds; i++) begin
        len_m[i]  = 0;
        fill_m[i] = 0;
      end
    end else begin
      if (snap.load) begin
        en_at_load = snap.en;
      end
      if (snap.out_hs) begin
        id = int'(snap.out_id);
        a  = lst_m[id][0];
        for (int k = 0; k < Capacity - 1; k++) begin
          lst_m[id][k] = lst_m[id][k+1];
        end
        len_m[id]--;
        fill_m[id]--;
        slot_v_m[a] = 1'b0;
      end
      if (snap.in_hs) begin
        id = int'(snap.in_id);
        pay_m[lst_m[id][fill_m[id]]] = snap.in_pay;
        fill_m[id]++;
      end
      if (snap.rsv_hs) begin
        id = int'(snap.rsv_id);
        lst_m[id][len_m[id]] = snap.rsv_addr;
        len_m[id]++;
        slot_v_m[snap.rsv_addr] = 1'b1;
      end
    end
  end

  always_comb begin
    logic found;
    found         = 1'b0;
    exp_free_addr = '0;
    for (int i = 0; i < Capacity; i++) begin
      if (!found && !slot_v_m[i]) begin
        exp_free_addr = bank_addr_t'(i);
        found         = 1'b1;
      end
    end
    exp_full         = !found;
    exp_in_ok        = len_m[i_in_resp.id] > fill_m[i_in_resp.id];
    // The output register holds the oldest entry of its identifier
    exp_front_addr   = lst_m[o_out_resp.id][0];
    exp_front_filled = fill_m[o_out_resp.id] != 0;
    exp_front_pay    = pay_m[exp_front_addr];
    exp_rel_onehot   = '0;
    if (o_out_valid && i_out_ready) begin
      exp_rel_onehot[exp_front_addr] = 1'b1;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic stop_on_error(input string msg);
    err_cnt++;
    $display("** Error at %0d ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  a_rsv_ready : assert property (@(posedge clk) disable iff (!rst_n)
    o_rsv_ready == !exp_full)
    else stop_on_error("reservation ready does not match the free slot count");
  a_rsv_addr : assert property (@(posedge clk) disable iff (!rst_n)
    i_rsv_valid && o_rsv_ready |-> o_rsv_addr == exp_free_addr)
    else stop_on_error("reservation address is not the lowest free slot");
  a_in_ready : assert property (@(posedge clk) disable iff (!rst_n)
    o_in_ready == (i_in_valid && exp_in_ok))
    else stop_on_error("input ready does not match the pending reservations");
  a_out_content : assert property (@(posedge clk) disable iff (!rst_n)
    o_out_valid |-> exp_front_filled && (o_out_resp.payload == exp_front_pay))
    else stop_on_error("output payload is not the oldest response of its id");
  a_out_release_en : assert property (@(posedge clk) disable iff (!rst_n)
    o_out_valid |-> en_at_load[exp_front_addr])
    else stop_on_error("output slot was popped without its release enable");
  a_out_hold : assert property (@(posedge clk) disable iff (!rst_n)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_resp))
    else stop_on_error("output changed while stalled");
  a_released : assert property (@(posedge clk) disable iff (!rst_n)
    o_released_onehot == exp_rel_onehot)
    else stop_on_error("released one-hot does not match the output slot");
  a_reset_state : assert property (@(posedge clk)
    $rose(rst_n) |-> !o_out_valid && !o_in_ready && o_rsv_ready && (o_rsv_addr == '0))
    else stop_on_error("wrong port state after reset");

  ////////////////////
  // Stimulus
  ////////////////////

  // First identifier from start onwards that still has an unfilled slot
  function automatic int pick_pending(input int start);
    int id;
    pick_pending = -1;
    for (int k = 0; k < NumIds; k++) begin
      id = (start + k) % NumIds;
      if (pick_pending < 0 && len_m[id] > fill_m[id]) begin
        pick_pending = id;
      end
    end
  endfunction

  function automatic bit model_empty();
    model_empty = 1'b1;
    for (int i = 0; i < NumIds; i++) begin
      if (len_m[i] != 0) begin
        model_empty = 1'b0;
      end
    end
  endfunction

  // Drain mode stops reservations and opens every release and the output
  task automatic drive_cycle(input bit drain);
    int id;
    id                = pick_pending(int'($urandom % NumIds));
    i_rsv_valid       = !drain && ($urandom % 3 == 0);
    i_rsv_id          = resp_id_t'($urandom % NumIds);
    i_in_valid        = (id >= 0) && (drain || ($urandom % 2 == 0));
    i_in_resp.id      = resp_id_t'((id >= 0) ? id : 0);
    i_in_resp.payload = PayloadWidth'($urandom);
    i_release_en      = drain ? '1 : Capacity'($urandom);
    i_out_ready       = drain || ($urandom % 4 != 0);
  endtask

  initial begin
    int unsigned seed_val;
    i_rsv_valid  = 1'b0;
    i_rsv_id     = '0;
    i_in_valid   = 1'b0;
    i_in_resp    = '0;
    i_out_ready  = 1'b0;
    i_release_en = '0;
    seed_val     = $urandom(Seed);
    wait (rst_n === 1'b1);
    repeat (NumTrans) begin
      @(posedge clk);
      #DriveDelay;
      drive_cycle(1'b0);
    end
    while (!model_empty()) begin
      @(posedge clk);
      #DriveDelay;
      drive_cycle(1'b1);
    end
    i_rsv_valid = 1'b0;
    i_in_valid  = 1'b0;
    repeat (4) @(posedge clk);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Hang guard sized from the number of stimulus cycles
  initial begin
    #(NumTrans * 50 * ClkPeriod);
    $display("Watchdog timeout: the bank did not drain before the time limit");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
// Testbench clock and reset source
// Free-running clock and an active-low reset held for a fixed number of cycles
`default_nettype none

module tb_clk_gen #(
  parameter int PeriodNs    = 20,
  parameter int ResetCycles = 8
) (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #(PeriodNs / 2) o_clk = ~o_clk;
  end

  // Reset leaves shortly after an edge, like every other driven input
  initial begin
    o_rst_n = 1'b0;
    repeat (ResetCycles) @(posedge o_clk);
    #2;
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- src/resp_bank_top.sv
// Response bank top level
// Connects the slot allocator, the queue controller, the payload
// storage and the output stage
`default_nettype none

module resp_bank_top #(
  parameter int NumIds       = resp_bank_pkg::NumIds,
  parameter int Capacity     = resp_bank_pkg::Capacity,
  parameter int PayloadWidth = resp_bank_pkg::PayloadWidth
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Reservation port
  input  logic                      i_rsv_valid,
  input  resp_bank_pkg::resp_id_t   i_rsv_id,
  output logic                      o_rsv_ready,
  output resp_bank_pkg::bank_addr_t o_rsv_addr,

  // Input port from the memory controller
  input  logic                      i_in_valid,
  input  resp_bank_pkg::resp_t      i_in_resp,
  output logic                      o_in_ready,

  // Output port to the requester
  output logic                      o_out_valid,
  output resp_bank_pkg::resp_t      o_out_resp,
  input  logic                      i_out_ready,

  // Release port
  input  logic [Capacity-1:0]       i_release_en,
  output logic [Capacity-1:0]       o_released_onehot
);

  import resp_bank_pkg::*;

  logic                    rsv_fire;
  logic                    wr_fire;
  bank_addr_t              wr_addr;
  pop_t                    pop;
  logic                    load_ready;
  logic [PayloadWidth-1:0] payload_rd;
  logic                    release_fire;
  bank_addr_t              release_addr;

  free_slot_alloc #(
    .Capacity (Capacity)
  ) u_free_slot_alloc (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_rsv_valid       (i_rsv_valid),
    .i_release_fire    (release_fire),
    .i_release_addr    (release_addr),
    .o_rsv_ready       (o_rsv_ready),
    .o_rsv_addr        (o_rsv_addr),
    .o_rsv_fire        (rsv_fire),
    .o_released_onehot (o_released_onehot)
  );

  id_queue_ctrl #(
    .NumIds   (NumIds),
    .Capacity (Capacity)
  ) u_id_queue_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_rsv_fire   (rsv_fire),
    .i_rsv_id     (i_rsv_id),
    .i_rsv_addr   (o_rsv_addr),
    .i_in_valid   (i_in_valid),
    .i_in_id      (i_in_resp.id),
    .i_release_en (i_release_en),
    .i_load_ready (load_ready),
    .o_in_ready   (o_in_ready),
    .o_wr_fire    (wr_fire),
    .o_wr_addr    (wr_addr),
    .o_pop        (pop)
  );

  // Payload storage, read at the slot being popped
  bank_ram #(
    .entry_t  (logic [PayloadWidth-1:0]),
    .Capacity (Capacity)
  ) u_payload_ram (
    .clk_i   (clk_i),
    .i_we    (wr_fire),
    .i_waddr (wr_addr),
    .i_wdata (i_in_resp.payload),
    .i_raddr (pop.addr),
    .o_rdata (payload_rd)
  );

  resp_out_stage #(
    .PayloadWidth (PayloadWidth)
  ) u_resp_out_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_pop          (pop),
    .i_payload      (payload_rd),
    .i_out_ready    (i_out_ready),
    .o_load_ready   (load_ready),
    .o_out_valid    (o_out_valid),
    .o_out_resp     (o_out_resp),
    .o_release_fire (release_fire),
    .o_release_addr (release_addr)
  );

endmodule

`default_nettype wire

//--- src/resp_out_stage.sv
// Output register of the response bank
// Loads the popped response, holds it under back-pressure and
// reports its slot for release on the output handshake
`default_nettype none

module resp_out_stage #(
  parameter int PayloadWidth = resp_bank_pkg::PayloadWidth
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Slot chosen by the queue controller and its stored payload
  input  resp_bank_pkg::pop_t       i_pop,
  input  logic [PayloadWidth-1:0]   i_payload,

  input  logic                      i_out_ready,
  output logic                      o_load_ready,
  output logic                      o_out_valid,
  output resp_bank_pkg::resp_t      o_out_resp,

  // Slot freed by the output handshake
  output logic                      o_release_fire,
  output resp_bank_pkg::bank_addr_t o_release_addr
);

  import resp_bank_pkg::*;

  logic       valid_q;
  resp_t      resp_q;
  bank_addr_t addr_q;

  ////////////////////
  // Load control
  ////////////////////

  // The register takes a new response when empty or drained this cycle
  // This keeps one response per cycle with ready held high
  assign o_load_ready = !valid_q || i_out_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (o_load_ready) begin
      valid_q <= i_pop.valid;
    end
  end

  // Payload and slot are only meaningful while valid is high
  always_ff @(posedge clk_i) begin
    if (o_load_ready && i_pop.valid) begin
      resp_q.id      <= i_pop.id;
      resp_q.payload <= i_payload;
      addr_q         <= i_pop.addr;
    end
  end

  ////////////////////
  // Output and release
  ////////////////////

  assign o_out_valid = valid_q;
  assign o_out_resp  = resp_q;

  // The held slot goes back to the allocator in the handshake cycle
  assign o_release_fire = valid_q && i_out_ready;
  assign o_release_addr = addr_q;

endmodule

`default_nettype wire

//--- src/id_queue_ctrl.sv
// Per-identifier queue controller of the response bank
// Keeps one linked list per identifier in the shared slot space, accepts
// responses into reserved slots and picks the next slot to pop
`default_nettype none

module id_queue_ctrl #(
  parameter int NumIds   = resp_bank_pkg::NumIds,
  parameter int Capacity = resp_bank_pkg::Capacity
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Reservation grant from the allocator
  input  logic                      i_rsv_fire,
  input  resp_bank_pkg::resp_id_t   i_rsv_id,
  input  resp_bank_pkg::bank_addr_t i_rsv_addr,

  // Response input from the memory controller
  input  logic                      i_in_valid,
  input  resp_bank_pkg::resp_id_t   i_in_id,

  // Multi-hot release enable, one bit per slot
  input  logic [Capacity-1:0]       i_release_en,

  // Output register can take a response this cycle
  input  logic                      i_load_ready,

  output logic                      o_in_ready,
  output logic                      o_wr_fire,
  output resp_bank_pkg::bank_addr_t o_wr_addr,
  output resp_bank_pkg::pop_t       o_pop
);

  import resp_bank_pkg::*;

  localparam int IdW  = $clog2(NumIds);
  localparam int CntW = $clog2(Capacity + 1);

  // List order is tail, then filled slots, then the response head, then
  // reserved slots up to the reservation head
  // The response head is only meaningful while rsv_len is nonzero
  bank_addr_t rsv_head_q [NumIds];
  bank_addr_t rsv_head_d [NumIds];
  bank_addr_t rsp_head_q [NumIds];
  bank_addr_t rsp_head_d [NumIds];
  bank_addr_t tail_q     [NumIds];
  bank_addr_t tail_d     [NumIds];

  // Reserved-unfilled and filled slot counts
  logic [CntW-1:0] rsv_len_q [NumIds];
  logic [CntW-1:0] rsv_len_d [NumIds];
  logic [CntW-1:0] rsp_len_q [NumIds];
  logic [CntW-1:0] rsp_len_d [NumIds];

  logic [NumIds-1:0] pop_elig;
  logic              pop_fire;
  logic              rsv_seed;
  logic              link_we;
  bank_addr_t        rsp_next;
  bank_addr_t        tail_next;

  ////////////////////
  // Input side
  ////////////////////

  // Ready waits for valid because it depends on the incoming identifier
  assign o_in_ready = i_in_valid && (rsv_len_q[i_in_id] != '0);
  assign o_wr_fire  = i_in_valid && o_in_ready;
  assign o_wr_addr  = rsp_head_q[i_in_id];

  ////////////////////
  // Pop selection
  ////////////////////

  // An identifier qualifies when its oldest response is filled and released
  for (genvar g = 0; g < NumIds; g++) begin : gen_elig
    assign pop_elig[g] = (rsp_len_q[g] != '0) && i_release_en[tail_q[g]];
  end

  // Lowest identifier first, so walk downwards and let later hits win
  always_comb begin
    o_pop = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (pop_elig[i]) begin
        o_pop.valid = 1'b1;
        o_pop.id    = IdW'(i);
        o_pop.addr  = tail_q[i];
      end
    end
  end

  assign pop_fire = o_pop.valid && i_load_ready;

  ////////////////////
  // Reservation side
  ////////////////////

  // A reservation into a queue that is empty after this cycle's pop starts
  // a new list, so no link is written and all pointers are seeded
  assign rsv_seed = (rsv_len_q[i_rsv_id] == '0) &&
                    ((rsp_len_q[i_rsv_id] == '0) ||
                     ((rsp_len_q[i_rsv_id] == CntW'(1)) && pop_fire &&
                      (o_pop.id == i_rsv_id)));

  // Otherwise the old reservation head links to the new slot
  assign link_we = i_rsv_fire && !rsv_seed;

  // The link table is read at the response head and at the tail in the
  // same cycle, so it is kept as two copies with a shared write
  bank_ram #(
    .entry_t  (bank_addr_t),
    .Capacity (Capacity)
  ) u_link_rsp (
    .clk_i   (clk_i),
    .i_we    (link_we),
    .i_waddr (rsv_head_q[i_rsv_id]),
    .i_wdata (i_rsv_addr),
    .i_raddr (rsp_head_q[i_in_id]),
    .o_rdata (rsp_next)
  );

  bank_ram #(
    .entry_t  (bank_addr_t),
    .Capacity (Capacity)
  ) u_link_pop (
    .clk_i   (clk_i),
    .i_we    (link_we),
    .i_waddr (rsv_head_q[i_rsv_id]),
    .i_wdata (i_rsv_addr),
    .i_raddr (o_pop.addr),
    .o_rdata (tail_next)
  );

  ////////////////////
  // Pointer update
  ////////////////////

  for (genvar g = 0; g < NumIds; g++) begin : gen_id
    logic in_hit;
    logic rsv_hit;
    logic pop_hit;

    assign in_hit  = o_wr_fire && (i_in_id == IdW'(g));
    assign rsv_hit = i_rsv_fire && (i_rsv_id == IdW'(g));
    assign pop_hit = pop_fire && (o_pop.id == IdW'(g));

    always_comb begin
      rsv_len_d[g]  = rsv_len_q[g];
      rsp_len_d[g]  = rsp_len_q[g];
      rsv_head_d[g] = rsv_head_q[g];
      rsp_head_d[g] = rsp_head_q[g];
      tail_d[g]     = tail_q[g];

      // An input fills the response head, which then follows its link
      // The link is only valid while more reserved slots remain
      if (in_hit) begin
        rsv_len_d[g] = rsv_len_d[g] - CntW'(1);
        rsp_len_d[g] = rsp_len_d[g] + CntW'(1);
        if (rsv_len_q[g] > CntW'(1)) begin
          rsp_head_d[g] = rsp_next;
        end
      end

      // A pop moves the tail to the next slot of the list
      if (pop_hit) begin
        rsp_len_d[g] = rsp_len_d[g] - CntW'(1);
        tail_d[g]    = tail_next;
      end

      if (rsv_hit) begin
        rsv_len_d[g]  = rsv_len_d[g] + CntW'(1);
        rsv_head_d[g] = i_rsv_addr;
        // No reserved slot left after the input, so the new one is next to fill
        if (rsv_len_q[g] == CntW'(in_hit)) begin
          rsp_head_d[g] = i_rsv_addr;
        end
        if (rsv_seed) begin
          tail_d[g] = i_rsv_addr;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_head_q <= '{default: '0};
      rsp_head_q <= '{default: '0};
      tail_q     <= '{default: '0};
      rsv_len_q  <= '{default: '0};
      rsp_len_q  <= '{default: '0};
    end else begin
      rsv_head_q <= rsv_head_d;
      rsp_head_q <= rsp_head_d;
      tail_q     <= tail_d;
      rsv_len_q  <= rsv_len_d;
      rsp_len_q  <= rsp_len_d;
    end
  end

  // An accepted input never lands on the slot currently offered to the
  // output stage, since that slot is already filled
  a_input_to_reserved_slot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    o_wr_fire |-> !(o_pop.valid && (o_pop.addr == o_wr_addr))
  );

endmodule

`default_nettype wire

//--- src/free_slot_alloc.sv
// Slot allocator of the response bank
// Keeps one valid bit per slot, offers the lowest free slot for
// reservation and frees slots when their response leaves the bank
`default_nettype none

module free_slot_alloc #(
  parameter int Capacity = resp_bank_pkg::Capacity
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Reservation request from the requester
  input  logic                      i_rsv_valid,

  // Release of the slot whose response completed its output handshake
  input  logic                      i_release_fire,
  input  resp_bank_pkg::bank_addr_t i_release_addr,

  output logic                      o_rsv_ready,
  output resp_bank_pkg::bank_addr_t o_rsv_addr,
  output logic                      o_rsv_fire,
  output logic [Capacity-1:0]       o_released_onehot
);

  import resp_bank_pkg::*;

  localparam int AddrW = $clog2(Capacity);

  logic [Capacity-1:0] slot_v_q;
  logic [Capacity-1:0] rsv_mask;
  logic [Capacity-1:0] rel_mask;
  bank_addr_t          free_addr;

  ////////////////////
  // Free slot search
  ////////////////////

  // Walk from the top down so the lowest clear bit wins
  always_comb begin
    free_addr = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!slot_v_q[i]) begin
        free_addr = i[AddrW-1:0];
      end
    end
  end

  // Ready only looks at the valid bits, never at the request
  assign o_rsv_ready = ~&slot_v_q;
  assign o_rsv_addr  = free_addr;
  assign o_rsv_fire  = i_rsv_valid && o_rsv_ready;

  ////////////////////
  // Valid bits
  ////////////////////

  // At most one bit set in each mask
  // They never overlap because a reserved slot is free and a released one is valid
  assign rsv_mask = o_rsv_fire ? (Capacity'(1) << free_addr) : '0;
  assign rel_mask = i_release_fire ? (Capacity'(1) << i_release_addr) : '0;

  // The released slot is reported in the handshake cycle itself
  assign o_released_onehot = rel_mask;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_v_q <= '0;
    end else begin
      slot_v_q <= (slot_v_q | rsv_mask) & ~rel_mask;
    end
  end

  // The output stage may only hand back a slot that was reserved earlier
  a_release_of_valid_slot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    i_release_fire |-> slot_v_q[i_release_addr]
  );

endmodule

`default_nettype wire

//--- src/bank_ram.sv
// Small register array used for payload storage and the link table
// Synchronous write, combinational read, one port of each
`default_nettype none

module bank_ram #(
  parameter type entry_t = logic,
  parameter int Capacity = resp_bank_pkg::Capacity
) (
  input  logic                      clk_i,

  // Write port, takes effect on the rising edge
  input  logic                      i_we,
  input  resp_bank_pkg::bank_addr_t i_waddr,
  input  entry_t                    i_wdata,

  // Read port, returns the stored entry in the same cycle
  input  resp_bank_pkg::bank_addr_t i_raddr,
  output entry_t                    o_rdata
);

  ////////////////////
  // Storage
  ////////////////////

  // One entry per slot
  entry_t mem_q [Capacity];

  // A write lands at the end of the cycle
  always_ff @(posedge clk_i) begin
    if (i_we) begin
      mem_q[i_waddr] <= i_wdata;
    end
  end

  ////////////////////
  // Read
  ////////////////////

  // Reading the address being written gives the old entry
  // The queue controller relies on this when a link is written and
  // read in the same cycle
  assign o_rdata = mem_q[i_raddr];

endmodule

`default_nettype wire

//--- src/resp_bank_pkg.sv
// Response bank shared definitions
// Sizes, address and identifier types, and the packed structs used
// between the queue controller and the output stage
`default_nettype none

package resp_bank_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Number of response identifiers, each with its own linked list
  parameter int NumIds = 4;
  parameter int IdWidth = $clog2(NumIds);

  // Slots shared by all identifiers
  parameter int Capacity = 8;
  parameter int AddrWidth = $clog2(Capacity);

  // Payload bits that follow the identifier in a response
  parameter int PayloadWidth = 8;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [AddrWidth-1:0] bank_addr_t;
  typedef logic [IdWidth-1:0] resp_id_t;

  // Identifier sits on the low side, the payload above it
  typedef struct packed {
    logic [PayloadWidth-1:0] payload;
    resp_id_t                id;
  } resp_t;

  // Next slot to load into the output register
  typedef struct packed {
    logic       valid;
    resp_id_t   id;
    bank_addr_t addr;
  } pop_t;

endpackage

`default_nettype wire
